// File: pd_pkg.sv
// USB PD sink package with timing constants, message types, FSM states and message structs
package pd_pkg;

	// ==============================
	// Timing in clock cycles
	// ==============================

	// Scaled down for simulation
	localparam integer POWER_ON_WAIT = 200;
	localparam integer GOODCRC_DELAY = 30;
	localparam integer RESP_TIMEOUT  = 2000;

	localparam integer TIMER_W = 12;
	localparam integer NUM_PDO = 7;

	// ==============================
	// Message and event codes
	// ==============================

	// Source_Capabilities also uses code 1, with one or more objects
	typedef enum logic [4:0] {
		MT_GOODCRC = 5'd1,
		MT_REQUEST = 5'd2,
		MT_ACCEPT  = 5'd3,
		MT_PS_RDY  = 5'd6
	} pd_msg_type_e;

	typedef enum logic [2:0] {
		EV_NONE,
		EV_SRC_CAP,
		EV_GOODCRC,
		EV_ACCEPT,
		EV_PS_RDY,
		EV_OTHER
	} pd_rx_event_e;

	typedef enum logic [3:0] {
		ST_PON,
		ST_CC_CHECK,
		ST_PON_WAIT,
		ST_WAIT_CAP,
		ST_CAP_ACK,
		ST_CAP_ACK_DONE,
		ST_REQ_SEND,
		ST_REQ_CRC,
		ST_WAIT_ACCEPT,
		ST_ACCEPT_ACK,
		ST_WAIT_PS_RDY,
		ST_PS_RDY_ACK,
		ST_READY,
		ST_IDLE,
		ST_ERROR
	} pd_state_e;

	// ==============================
	// Messages to and from the PHY
	// ==============================
	typedef struct packed {
		logic                     crc_ok;
		logic                     pkg_ok;
		pd_msg_type_e             msg_type;
		logic [2:0]               num_obj;
		logic [NUM_PDO-1:0][31:0] words;
	} pd_rx_msg_t;

	typedef struct packed {
		logic [4:0]  msg_type;
		logic [2:0]  num_obj;
		logic [31:0] word0;
	} pd_tx_msg_t;

endpackage

// File: pd_rx_decode.sv
// Receive decoder turning each valid PHY message into a single-cycle event
`timescale 1ns/10ps

module pd_rx_decode
	import pd_pkg::*;
(
	input  logic         glb_clk,
	input  logic         glb_nrst,
	input  pd_rx_msg_t   rx_msg,
	input  logic         rx_busy,
	output pd_rx_event_e rx_event
);

	logic msg_valid;
	logic msg_valid_q;

	assign msg_valid = rx_busy & rx_msg.crc_ok & rx_msg.pkg_ok;

	always_ff @(posedge glb_clk) begin
		if (!glb_nrst) begin
			msg_valid_q <= 1'b0;
			rx_event <= EV_NONE;
		end else begin
			msg_valid_q <= msg_valid;
			// Only the first valid cycle of a message counts
			if (msg_valid && !msg_valid_q) begin
				case (rx_msg.msg_type)
					MT_GOODCRC: begin
						if (rx_msg.num_obj != 3'd0) begin
							rx_event <= EV_SRC_CAP;
						end else begin
							rx_event <= EV_GOODCRC;
						end
					end
					MT_ACCEPT: rx_event <= EV_ACCEPT;
					MT_PS_RDY: rx_event <= EV_PS_RDY;
					default:   rx_event <= EV_OTHER;
				endcase
			end else begin
				rx_event <= EV_NONE;
			end
		end
	end

	// ==============================
	// Assertions
	// ==============================

	// One message never yields back-to-back events
	a_event_single: assert property (
		@(posedge glb_clk) disable iff (!glb_nrst)
		(rx_event != EV_NONE) |=> (rx_event == EV_NONE)
	);

endmodule

// File: pd_pdo_select.sv
// Source capability store, fixed supply match and request data object build
`timescale 1ns/10ps

module pd_pdo_select
	import pd_pkg::*;
#(
	parameter logic [9:0] target_mv50 = 10'd100
)(
	input  logic         glb_clk,
	input  logic         glb_nrst,
	input  pd_rx_event_e rx_event,
	input  pd_rx_msg_t   rx_msg,
	output logic [31:0]  rdo,
	output logic         rdo_ok
);

	logic [NUM_PDO-1:0][31:0] cap_words;
	logic [2:0]               cap_num;
	logic                     search_pend;
	logic                     hit;
	logic [2:0]               hit_idx;
	logic [31:0]              hit_pdo;

	// Capability payload
	always_ff @(posedge glb_clk) begin
		if (rx_event == EV_SRC_CAP) begin
			cap_words <= rx_msg.words;
		end
	end

	always_ff @(posedge glb_clk) begin
		if (!glb_nrst) begin
			cap_num <= 3'd0;
			search_pend <= 1'b0;
			rdo_ok <= 1'b0;
		end else if (rx_event == EV_SRC_CAP) begin
			cap_num <= rx_msg.num_obj;
			search_pend <= 1'b1;
			rdo_ok <= 1'b0;
		end else if (search_pend) begin
			search_pend <= 1'b0;
			rdo_ok <= hit;
		end
	end

	// Walk downwards so the lowest matching index wins
	always_comb begin
		hit = 1'b0;
		hit_idx = 3'd0;
		for (int i = NUM_PDO - 1; i >= 0; i--) begin
			if ((i < int'(cap_num)) && (cap_words[i][19:10] == target_mv50)) begin
				hit = 1'b1;
				hit_idx = 3'(i);
			end
		end
	end

	assign hit_pdo = cap_words[hit_idx];

	// Object position, then max and operating current from the PDO
	always_ff @(posedge glb_clk) begin
		if (search_pend) begin
			rdo <= {1'b0, hit_idx + 3'd1, 8'd0, hit_pdo[9:0], hit_pdo[9:0]};
		end
	end

	// ==============================
	// Assertions
	// ==============================
	a_rdo_position: assert property (
		@(posedge glb_clk) disable iff (!glb_nrst)
		rdo_ok |-> (rdo[30:28] != 3'd0)
	);

endmodule

// File: pd_sink_fsm.sv
// USB PD sink policy FSM with delay and timeout counter, transmit control and status
`timescale 1ns/10ps

module pd_sink_fsm
	import pd_pkg::*;
(
	input  logic         glb_clk,
	input  logic         glb_nrst,
	input  pd_rx_event_e rx_event,
	input  logic         rx_busy,
	input  logic [31:0]  rdo,
	input  logic         rdo_ok,
	input  logic         cc_lock,
	input  logic         phy_discon,
	input  logic         tx_busy,
	output logic         tx_start,
	output pd_tx_msg_t   tx_msg,
	output logic         cc_check,
	output logic         pd_ready,
	output logic         pd_error
);

	pd_state_e          state;
	logic [TIMER_W-1:0] timer;
	logic               tx_wait;
	logic               delay_done;
	logic               resp_expired;

	logic               send_state;
	pd_state_e          send_next;
	pd_tx_msg_t         send_msg;

	logic               wait_state;
	pd_rx_event_e       wait_ev;
	pd_state_e          wait_next;

	assign delay_done   = (timer >= TIMER_W'(GOODCRC_DELAY));
	assign resp_expired = (timer >= TIMER_W'(RESP_TIMEOUT));

	// Transmit states and what they send
	always_comb begin
		send_state = 1'b1;
		send_next = ST_PON;
		send_msg = '{msg_type: MT_GOODCRC, num_obj: 3'd0, word0: 32'd0};
		case (state)
			ST_CAP_ACK:    send_next = ST_CAP_ACK_DONE;
			ST_REQ_SEND: begin
				send_next = ST_REQ_CRC;
				send_msg = '{msg_type: MT_REQUEST, num_obj: 3'd1, word0: rdo};
			end
			ST_ACCEPT_ACK: send_next = ST_WAIT_PS_RDY;
			ST_PS_RDY_ACK: send_next = ST_READY;
			default:       send_state = 1'b0;
		endcase
	end

	// Response waits and the event each one expects
	always_comb begin
		wait_state = 1'b1;
		wait_ev = EV_NONE;
		wait_next = ST_IDLE;
		case (state)
			ST_REQ_CRC: begin
				wait_ev = EV_GOODCRC;
				wait_next = ST_WAIT_ACCEPT;
			end
			ST_WAIT_ACCEPT: begin
				wait_ev = EV_ACCEPT;
				wait_next = ST_ACCEPT_ACK;
			end
			ST_WAIT_PS_RDY: begin
				wait_ev = EV_PS_RDY;
				wait_next = ST_PS_RDY_ACK;
			end
			default: wait_state = 1'b0;
		endcase
	end

	// ==============================
	// Main FSM
	// ==============================
	always_ff @(posedge glb_clk) begin
		if (!glb_nrst) begin
			state <= ST_PON;
			timer <= '0;
			tx_start <= 1'b0;
			tx_wait <= 1'b0;
		end else begin
			// End of transmit is seen in any state
			if (tx_wait && !tx_busy) begin
				tx_wait <= 1'b0;
			end

			if (send_state) begin
				if (tx_start) begin
					if (tx_busy) begin
						tx_start <= 1'b0;
						tx_wait <= 1'b1;
						timer <= '0;
						state <= send_next;
					end
				end else if (tx_wait) begin
					timer <= '0;
				end else if (!delay_done) begin
					timer <= timer + 1'b1;
				end else if (!rx_busy) begin
					tx_start <= 1'b1;
					tx_msg <= send_msg;
				end
			end else if (wait_state) begin
				if (rx_event == wait_ev) begin
					timer <= '0;
					state <= wait_next;
				end else if (tx_wait) begin
					timer <= '0;
				end else if (resp_expired) begin
					state <= ST_IDLE;
				end else begin
					timer <= timer + 1'b1;
				end
			end else begin
				case (state)
					ST_PON: begin
						timer <= '0;
						tx_start <= 1'b0;
						tx_wait <= 1'b0;
						state <= ST_CC_CHECK;
					end
					ST_CC_CHECK: begin
						if (cc_lock) begin
							timer <= '0;
							state <= ST_PON_WAIT;
						end
					end
					ST_PON_WAIT: begin
						if (timer >= TIMER_W'(POWER_ON_WAIT)) begin
							timer <= '0;
							state <= ST_WAIT_CAP;
						end else begin
							timer <= timer + 1'b1;
						end
					end
					// Source repeats its capabilities until answered
					ST_WAIT_CAP: begin
						if (rx_event == EV_SRC_CAP) begin
							timer <= '0;
							state <= ST_CAP_ACK;
						end
					end
					ST_CAP_ACK_DONE: begin
						timer <= '0;
						if (!tx_wait) begin
							state <= rdo_ok ? ST_REQ_SEND : ST_ERROR;
						end
					end
					ST_READY, ST_IDLE: begin
						if (phy_discon) begin
							state <= ST_PON;
						end
					end
					// Stays here until reset
					ST_ERROR: begin
						tx_start <= 1'b0;
					end
					default: state <= ST_PON;
				endcase
			end
		end
	end

	assign cc_check = (state == ST_CC_CHECK);
	assign pd_ready = (state == ST_READY) && !tx_wait;
	assign pd_error = (state == ST_ERROR);

	// ==============================
	// Assertions
	// ==============================

	// PHY may sample the message on any cycle of the start request
	a_tx_msg_stable: assert property (
		@(posedge glb_clk) disable iff (!glb_nrst)
		tx_start |=> (!tx_start || $stable(tx_msg))
	);

	a_no_tx_in_error: assert property (
		@(posedge glb_clk) disable iff (!glb_nrst)
		!(tx_start && pd_error)
	);

endmodule

// File: pd_sink_top.sv
// USB PD sink policy engine top level joining decoder, PDO selector and FSM
`timescale 1ns/10ps

module pd_sink_top
	import pd_pkg::*;
#(
	parameter logic [9:0] target_mv50 = 10'd100
)(
	input  logic       glb_clk,
	input  logic       glb_nrst,
	input  pd_rx_msg_t rx_msg,
	input  logic       rx_busy,
	input  logic       tx_busy,
	output logic       tx_start,
	output pd_tx_msg_t tx_msg,
	input  logic       cc_lock,
	input  logic       phy_discon,
	output logic       cc_check,
	output logic       pd_ready,
	output logic       pd_error
);

	pd_rx_event_e rx_event;
	logic [31:0]  rdo;
	logic         rdo_ok;

	pd_rx_decode u_rx_decode (
		.glb_clk  (glb_clk),
		.glb_nrst (glb_nrst),
		.rx_msg   (rx_msg),
		.rx_busy  (rx_busy),
		.rx_event (rx_event)
	);

	pd_pdo_select #(
		.target_mv50 (target_mv50)
	) u_pdo_select (
		.glb_clk  (glb_clk),
		.glb_nrst (glb_nrst),
		.rx_event (rx_event),
		.rx_msg   (rx_msg),
		.rdo      (rdo),
		.rdo_ok   (rdo_ok)
	);

	pd_sink_fsm u_sink_fsm (
		.glb_clk    (glb_clk),
		.glb_nrst   (glb_nrst),
		.rx_event   (rx_event),
		.rx_busy    (rx_busy),
		.rdo        (rdo),
		.rdo_ok     (rdo_ok),
		.cc_lock    (cc_lock),
		.phy_discon (phy_discon),
		.tx_busy    (tx_busy),
		.tx_start   (tx_start),
		.tx_msg     (tx_msg),
		.cc_check   (cc_check),
		.pd_ready   (pd_ready),
		.pd_error   (pd_error)
	);

endmodule

// File: tb_pd_sink_tasks.svh
// Testbench tasks for PHY message injection, transmit and level waits, and value checks

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			errors = errors + 1;
			$display("CHECK FAILED at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
		end
	endtask

	// BMC reader holds the message for 10 cycles
	task automatic send_msg(input pd_msg_type_e mt, input logic [2:0] num,
			input logic [NUM_PDO-1:0][31:0] words, input logic crc);
		@(posedge glb_clk);
		#1;
		rx_msg.crc_ok = crc;
		rx_msg.pkg_ok = 1'b1;
		rx_msg.msg_type = mt;
		rx_msg.num_obj = num;
		rx_msg.words = words;
		rx_busy = 1'b1;
		repeat (10) @(posedge glb_clk);
		#1;
		rx_busy = 1'b0;
		rx_msg = '0;
		repeat (2) @(posedge glb_clk);
	endtask

	// Next finished transmit from the DUT
	task automatic wait_tx(output pd_tx_msg_t m);
		integer n;
		n = 0;
		m = '0;
		while (tx_log.size() == 0 && n < WAIT_LIMIT) begin
			@(negedge glb_clk);
			n = n + 1;
		end
		if (tx_log.size() == 0) begin
			timeouts = timeouts + 1;
			$display("Timeout at %0t: the DUT sent no message", $time);
		end else begin
			m = tx_log.pop_front();
		end
	endtask

	task automatic wait_level(input string name, input logic level);
		integer n;
		logic hit;
		n = 0;
		hit = 1'b0;
		while (!hit && n < WAIT_LIMIT) begin
			@(negedge glb_clk);
			n = n + 1;
			if (name == "cc_check") begin
				hit = (cc_check === level);
			end else if (name == "pd_ready") begin
				hit = (pd_ready === level);
			end else begin
				hit = (pd_error === level);
			end
		end
		if (!hit) begin
			timeouts = timeouts + 1;
			$display("Timeout at %0t: %s never went to %0b", $time, name, level);
		end
	endtask

	// Lock ends the line check, then the power-on wait runs
	task automatic await_listen();
		wait_level("cc_check", 1'b0);
		repeat (POWER_ON_WAIT + 10) @(posedge glb_clk);
	endtask

// File: tb_pd_sink_top.sv
// Testbench for the USB PD sink policy engine with a PHY model and directed tests
`timescale 1ns/10ps

module tb_pd_sink_top
	import pd_pkg::*;
();

	localparam integer     WAIT_LIMIT = RESP_TIMEOUT * 3;
	localparam logic [9:0] TARGET     = 10'd100;

	logic       glb_clk;
	logic       glb_nrst;
	pd_rx_msg_t rx_msg;
	logic       rx_busy;
	logic       tx_busy;
	logic       tx_start;
	pd_tx_msg_t tx_msg;
	logic       cc_lock;
	logic       phy_discon;
	logic       cc_check;
	logic       pd_ready;
	logic       pd_error;

	integer     seed;
	integer     errors;
	integer     timeouts;
	integer     tx_count;
	pd_tx_msg_t tx_log[$];
	pd_tx_msg_t tx_cap;
	logic       lock_req;

	pd_sink_top #(
		.target_mv50 (TARGET)
	) u_dut (
		.glb_clk    (glb_clk),
		.glb_nrst   (glb_nrst),
		.rx_msg     (rx_msg),
		.rx_busy    (rx_busy),
		.tx_busy    (tx_busy),
		.tx_start   (tx_start),
		.tx_msg     (tx_msg),
		.cc_lock    (cc_lock),
		.phy_discon (phy_discon),
		.cc_check   (cc_check),
		.pd_ready   (pd_ready),
		.pd_error   (pd_error)
	);

	always #4 glb_clk = ~glb_clk;

	// ==============================
	// PHY model
	// ==============================

	// CC front end locks one cycle after the check request
	always begin
		@(negedge glb_clk);
		lock_req = (cc_check === 1'b1);
		@(posedge glb_clk);
		#1 cc_lock = lock_req;
	end

	// BMC writer, busy for 20 cycles per message
	always begin
		@(negedge glb_clk);
		if (tx_start === 1'b1 && tx_busy === 1'b0) begin
			tx_cap = tx_msg;
			tx_count = tx_count + 1;
			@(posedge glb_clk);
			#1 tx_busy = 1'b1;
			repeat (20) @(posedge glb_clk);
			#1 tx_busy = 1'b0;
			tx_log.push_back(tx_cap);
		end
	end

	`include "tb_pd_sink_tasks.svh"

	function automatic logic [31:0] fixed_pdo(input logic [9:0] mv50, input logic [9:0] ma10);
		return {12'd0, mv50, ma10};
	endfunction

	function automatic logic [9:0] other_volt();
		logic [9:0] v;
		v = 10'($random(seed));
		if (v == TARGET) begin
			v = v + 10'd1;
		end
		return v;
	endfunction

	function automatic logic [NUM_PDO-1:0][31:0] no_match_caps();
		logic [NUM_PDO-1:0][31:0] w;
		for (int i = 0; i < NUM_PDO; i++) begin
			w[i] = fixed_pdo(other_volt(), 10'd50 + 10'(i));
		end
		return w;
	endfunction

	// Position in 30:28, PDO max current in both current fields
	function automatic logic [31:0] expected_rdo(input logic [2:0] pos, input logic [31:0] pdo);
		logic [31:0] r;
		r = 32'd0;
		r[30:28] = pos;
		r[19:10] = pdo[9:0];
		r[9:0] = pdo[9:0];
		return r;
	endfunction

	task automatic apply_reset();
		@(posedge glb_clk);
		#1;
		glb_nrst = 1'b0;
		repeat (4) @(posedge glb_clk);
		#1;
		glb_nrst = 1'b1;
	endtask

	task automatic pulse_discon();
		@(posedge glb_clk);
		#1;
		phy_discon = 1'b1;
		@(posedge glb_clk);
		#1;
		phy_discon = 1'b0;
	endtask

	// ==============================
	// Directed tests
	// ==============================
	task automatic test_reset();
		apply_reset();
		check_value("tx_start", tx_start, 0);
		check_value("cc_check", cc_check, 0);
		check_value("pd_ready", pd_ready, 0);
		check_value("pd_error", pd_error, 0);
		wait_level("cc_check", 1'b1);
	endtask

	task automatic test_full_contract();
		logic [NUM_PDO-1:0][31:0] caps;
		pd_tx_msg_t m;
		caps = no_match_caps();
		caps[2] = fixed_pdo(TARGET, 10'd300);
		await_listen();
		send_msg(MT_GOODCRC, 3'd4, caps, 1'b1);
		wait_tx(m);
		check_value("tx_msg.msg_type", m.msg_type, MT_GOODCRC);
		wait_tx(m);
		check_value("tx_msg.msg_type", m.msg_type, MT_REQUEST);
		check_value("tx_msg.num_obj", m.num_obj, 1);
		check_value("tx_msg.word0", m.word0, expected_rdo(3'd3, caps[2]));
		send_msg(MT_GOODCRC, 3'd0, '0, 1'b1);
		send_msg(MT_ACCEPT, 3'd0, '0, 1'b1);
		wait_tx(m);
		check_value("tx_msg.msg_type", m.msg_type, MT_GOODCRC);
		send_msg(MT_PS_RDY, 3'd0, '0, 1'b1);
		wait_tx(m);
		check_value("tx_msg.msg_type", m.msg_type, MT_GOODCRC);
		wait_level("pd_ready", 1'b1);
	endtask

	// Lowest position inside the object count wins
	task automatic test_priority();
		logic [NUM_PDO-1:0][31:0] caps;
		pd_tx_msg_t m;
		caps = no_match_caps();
		caps[1] = fixed_pdo(TARGET, 10'd150);
		caps[3] = fixed_pdo(TARGET, 10'd200);
		caps[4] = fixed_pdo(TARGET, 10'd250);
		caps[6] = fixed_pdo(TARGET, 10'd350);
		pulse_discon();
		wait_level("cc_check", 1'b1);
		await_listen();
		send_msg(MT_GOODCRC, 3'd4, caps, 1'b1);
		wait_tx(m);
		check_value("tx_msg.msg_type", m.msg_type, MT_GOODCRC);
		wait_tx(m);
		check_value("tx_msg.msg_type", m.msg_type, MT_REQUEST);
		check_value("tx_msg.word0", m.word0, expected_rdo(3'd2, caps[1]));
	endtask

	// No GoodCRC for the pending Request
	task automatic test_timeout_restart();
		integer start;
		start = tx_count;
		repeat (RESP_TIMEOUT + 100) @(negedge glb_clk);
		check_value("transmit count", tx_count, start);
		check_value("pd_ready", pd_ready, 0);
		check_value("cc_check", cc_check, 0);
		pulse_discon();
		wait_level("cc_check", 1'b1);
	endtask

	task automatic test_bad_crc();
		logic [NUM_PDO-1:0][31:0] caps;
		pd_tx_msg_t m;
		integer start;
		caps = no_match_caps();
		caps[0] = fixed_pdo(TARGET, 10'd100);
		await_listen();
		start = tx_count;
		send_msg(MT_GOODCRC, 3'd2, caps, 1'b0);
		repeat (GOODCRC_DELAY + 40) @(negedge glb_clk);
		check_value("transmit count", tx_count, start);
		send_msg(MT_GOODCRC, 3'd2, caps, 1'b1);
		wait_tx(m);
		check_value("tx_msg.msg_type", m.msg_type, MT_GOODCRC);
		wait_tx(m);
		check_value("tx_msg.word0", m.word0, expected_rdo(3'd1, caps[0]));
	endtask

	task automatic test_no_match();
		logic [NUM_PDO-1:0][31:0] caps;
		pd_tx_msg_t m;
		integer start;
		apply_reset();
		wait_level("cc_check", 1'b1);
		await_listen();
		caps = no_match_caps();
		start = tx_count;
		send_msg(MT_GOODCRC, 3'd7, caps, 1'b1);
		wait_tx(m);
		check_value("tx_msg.msg_type", m.msg_type, MT_GOODCRC);
		wait_level("pd_error", 1'b1);
		repeat (GOODCRC_DELAY + 40) @(negedge glb_clk);
		check_value("transmit count", tx_count, start + 1);
		check_value("pd_ready", pd_ready, 0);
		check_value("tx_start", tx_start, 0);
	endtask

	initial begin
		glb_clk = 1'b0;
		glb_nrst = 1'b0;
		rx_msg = '0;
		rx_busy = 1'b0;
		tx_busy = 1'b0;
		cc_lock = 1'b0;
		phy_discon = 1'b0;
		seed = 70249;
		errors = 0;
		timeouts = 0;
		tx_count = 0;

		test_reset();
		test_full_contract();
		test_priority();
		test_timeout_restart();
		test_bad_crc();
		test_no_match();

		$display("Closing report: %0d check errors, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

// File: pd_sink_top.f
+incdir+.
pd_pkg.sv
pd_rx_decode.sv
pd_pdo_select.sv
pd_sink_fsm.sv
pd_sink_top.sv
tb_pd_sink_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f pd_sink_top.f --top-module tb_pd_sink_top -o tb_pd_sink_top

sim_out=$(./obj_dir/tb_pd_sink_top)
echo "$sim_out"

if echo "$sim_out" | grep -qx ">>> PASS"; then
	exit 0
fi
exit 1
